//--- hw/csr_pkg.sv
/* Shared CSR definitions for an RV32 M-mode only core.
   Addresses follow the privileged spec; MEIE0/MEIP0/MLEI are custom. */

package csr_pkg;

	localparam int XLEN = 32; // RV32 only

	typedef logic [11:0] csr_addr_t;

	// --------------------
	// Register map
	localparam csr_addr_t CSR_MSTATUS       = 12'h300;
	localparam csr_addr_t CSR_MISA          = 12'h301;
	localparam csr_addr_t CSR_MIE           = 12'h304;
	localparam csr_addr_t CSR_MTVEC         = 12'h305;
	localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
	localparam csr_addr_t CSR_MSCRATCH      = 12'h340;
	localparam csr_addr_t CSR_MEPC          = 12'h341;
	localparam csr_addr_t CSR_MCAUSE        = 12'h342;
	localparam csr_addr_t CSR_MTVAL         = 12'h343;
	localparam csr_addr_t CSR_MIP           = 12'h344;
	localparam csr_addr_t CSR_MCYCLE        = 12'hb00;
	localparam csr_addr_t CSR_MINSTRET      = 12'hb02;
	localparam csr_addr_t CSR_MCYCLEH       = 12'hb80;
	localparam csr_addr_t CSR_MINSTRETH     = 12'hb82;
	localparam csr_addr_t CSR_MEIE0         = 12'hbe0; // Custom, external enables
	localparam csr_addr_t CSR_MEIP0         = 12'hfe0; // Custom, RO pending
	localparam csr_addr_t CSR_MLEI          = 12'hfe4; // Custom, RO lowest pending
	localparam csr_addr_t CSR_MVENDORID     = 12'hf11;
	localparam csr_addr_t CSR_MARCHID       = 12'hf12;
	localparam csr_addr_t CSR_MIMPID        = 12'hf13;
	localparam csr_addr_t CSR_MHARTID       = 12'hf14;

	// Identification, read only
	localparam logic [XLEN-1:0] VENDOR_ID = 32'h0000_0000; // Non-commercial
	localparam logic [XLEN-1:0] ARCH_ID   = 32'h0000_001b;
	localparam logic [XLEN-1:0] IMP_ID    = 32'h0000_0102;
	localparam logic [XLEN-1:0] HART_ID   = 32'h0000_0000; // Single hart

	// Writable bits of the masked trap registers
	localparam logic [XLEN-1:0] MIE_WMASK   = 32'h0000_0888; // meie, mtie, msie
	localparam logic [XLEN-1:0] MTVEC_WMASK = 32'hffff_fffd; // Base and mode bit 0

	// --------------------
	// Write kinds, matching the csrrw/csrrs/csrrc funct3 low bits
	typedef enum logic [1:0] {
		WTYPE_W = 2'h0,
		WTYPE_S = 2'h1,
		WTYPE_C = 2'h2
	} csr_wtype_t;

	// 0..11 are mcause exception codes
	typedef logic [3:0] except_t;
	localparam except_t EXCEPT_MRET = 4'd14;
	localparam except_t EXCEPT_NONE = 4'd15; // Idle

	typedef struct packed {
		csr_addr_t       addr;
		logic [XLEN-1:0] wdata;
		logic            wen;
		csr_wtype_t      wtype;
	} csr_wreq_t;

	// Read-only views from the trap unit
	typedef struct packed {
		logic            mstatus_mie;
		logic            mstatus_mpie;
		logic [XLEN-1:0] mtvec_reg;   // Raw, bit 1 may be stale
		logic [XLEN-1:0] mepc;
		logic            mcause_irq;
		logic [4:0]      mcause_code;
		logic [XLEN-1:0] mie;
		logic [XLEN-1:0] mip;
		logic [XLEN-1:0] meie0;
		logic [XLEN-1:0] meip0;
		logic [4:0]      mlei;
		logic [XLEN-1:0] mscratch;
	} trap_view_t;

	typedef struct packed {
		logic [XLEN-1:0] mcycle;
		logic [XLEN-1:0] mcycleh;
		logic [XLEN-1:0] minstret;
		logic [XLEN-1:0] minstreth;
		logic            inhibit_cy;
		logic            inhibit_ir;
	} ctr_view_t;

	// Write/set/clear of one register; bits outside wmask keep prev
	function automatic logic [XLEN-1:0] csr_update(input logic [XLEN-1:0] prev,
		input csr_wreq_t req, input logic [XLEN-1:0] wmask);
		logic [XLEN-1:0] raw;
		case (req.wtype)
			WTYPE_S: raw = prev | req.wdata;
			WTYPE_C: raw = prev & ~req.wdata;
			default: raw = req.wdata;
		endcase
		return (raw & wmask) | (prev & ~wmask);
	endfunction

endpackage

//--- hw/csr_priority_encode.sv
/* Lowest set request bit wins. gnt is zero when nothing is requested,
   so callers must qualify it with their own "any" flag. */
`timescale 1ns/1ps

module csr_priority_encode #(
	parameter int W_REQ = 16,
	parameter int W_GNT = 4  // Must hold W_REQ-1
) (
	input  logic [W_REQ-1:0] req,
	output logic [W_GNT-1:0] gnt
);

	// Scan from the top so the lowest index is written last
	always_comb begin
		gnt = '0;
		for (int i = W_REQ - 1; i >= 0; i--) begin
			if (req[i]) begin
				gnt = W_GNT'(i);
			end
		end
	end

endmodule

//--- hw/csr_trap_unit.sv
/* NUM_IRQ must not exceed 16, so external vectors (16+n) fit mcause.
   Exceptions beat interrupts; standard interrupts beat external ones. */
`timescale 1ns/1ps

module csr_trap_unit import csr_pkg::*; #(
	parameter int              NUM_IRQ    = 16,
	parameter logic [XLEN-1:0] MTVEC_INIT = '0
) (
	input  logic               clk,
	input  logic               rst_n,
	input  csr_wreq_t          wreq,
	input  except_t            except,
	input  logic [NUM_IRQ-1:0] irq,
	input  logic               irq_software,
	input  logic               irq_timer,
	input  logic [XLEN-1:0]    mepc_in,
	input  logic               trap_enter_rdy,
	output logic [XLEN-1:0]    trap_addr,
	output logic               trap_is_irq,
	output logic               trap_enter_vld,
	output trap_view_t         view
);

	localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h0000_0088; // mpie, mie
	localparam logic [XLEN-1:0] MCAUSE_WMASK  = 32'h8000_001f;
	localparam logic [XLEN-1:0] MEPC_WMASK    = 32'hffff_fffe; // Bit 0 stays clear
	localparam logic [XLEN-1:0] MEIE0_WMASK   = ~({XLEN{1'b1}} << NUM_IRQ);

	logic mstatus_mie, mstatus_mpie;
	logic [XLEN-1:0] mtvec_reg, mepc, mie, meie0, mscratch;
	logic mcause_irq;
	logic [4:0] mcause_code;
	logic [NUM_IRQ-1:0] irq_r;
	logic irq_software_r, irq_timer_r;
	logic [XLEN-1:0] mip, mstatus_wr, mcause_wr;
	logic ext_pending, std_active, ext_active, except_any, is_mret, trap_accept;
	logic [4:0] ext_num;
	logic [3:0] std_num;
	logic [5:0] vector_sel;

	assign except_any  = except != EXCEPT_NONE; // MRET counts here too
	assign is_mret     = except == EXCEPT_MRET;
	assign trap_accept = trap_enter_vld && trap_enter_rdy;

	// Full-width images so csr_update can handle the sparse fields
	assign mstatus_wr = csr_update({24'h0, mstatus_mpie, 3'h0, mstatus_mie, 3'h0},
		wreq, MSTATUS_WMASK);
	assign mcause_wr  = csr_update({mcause_irq, {(XLEN-6){1'b0}}, mcause_code},
		wreq, MCAUSE_WMASK);

	// --------------------
	// Trap entry beats a software write to the same register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
			mtvec_reg    <= MTVEC_INIT;
			mepc         <= '0;
			mcause_irq   <= 1'b0;
			mcause_code  <= '0;
			mie          <= '0;
			meie0        <= '0;
			mscratch     <= '0;
		end else begin
			if (trap_accept && !is_mret) begin
				mstatus_mpie <= mstatus_mie;  // Push
				mstatus_mie  <= 1'b0;
				mepc         <= mepc_in & MEPC_WMASK;
				mcause_irq   <= !except_any;
				mcause_code  <= except_any ? {1'b0, except} : vector_sel[4:0];
			end else if (wreq.wen) begin
				case (wreq.addr)
					CSR_MSTATUS: {mstatus_mpie, mstatus_mie} <= {mstatus_wr[7], mstatus_wr[3]};
					CSR_MEPC:    mepc <= csr_update(mepc, wreq, MEPC_WMASK);
					CSR_MCAUSE:  {mcause_irq, mcause_code} <= {mcause_wr[31], mcause_wr[4:0]};
					default: ;
				endcase
			end
			// MRET only owns mstatus and overrides a write to it
			if (trap_accept && is_mret) begin
				mstatus_mie  <= mstatus_mpie; // Pop the enable stack
				mstatus_mpie <= 1'b1;
			end
			// Never touched by trap entry
			if (wreq.wen && wreq.addr == CSR_MTVEC)
				mtvec_reg <= csr_update(mtvec_reg, wreq, MTVEC_WMASK);
			if (wreq.wen && wreq.addr == CSR_MIE)
				mie <= csr_update(mie, wreq, MIE_WMASK);
			if (wreq.wen && wreq.addr == CSR_MEIE0)
				meie0 <= csr_update(meie0, wreq, MEIE0_WMASK);
			if (wreq.wen && wreq.addr == CSR_MSCRATCH)
				mscratch <= csr_update(mscratch, wreq, '1);
		end
	end

	// --------------------
	// One sampling flop per interrupt input
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_r          <= '0;
			irq_software_r <= 1'b0;
			irq_timer_r    <= 1'b0;
		end else begin
			irq_r          <= irq;
			irq_software_r <= irq_software;
			irq_timer_r    <= irq_timer;
		end
	end

	assign ext_pending = |(meie0[NUM_IRQ-1:0] & irq_r);
	assign mip = {20'h0, ext_pending, 3'h0, irq_timer_r, 3'h0, irq_software_r, 3'h0};

	// meip masked out since external lines vector through ext_encode
	csr_priority_encode #(.W_REQ(16), .W_GNT(4)) std_encode (
		.req (mip[15:0] & mie[15:0] & ~16'h0800),
		.gnt (std_num)
	);

	csr_priority_encode #(.W_REQ(NUM_IRQ), .W_GNT(5)) ext_encode (
		.req (meie0[NUM_IRQ-1:0] & irq_r),
		.gnt (ext_num)
	);

	assign std_active = mstatus_mie && |(mip[15:0] & mie[15:0] & ~16'h0800);
	assign ext_active = mstatus_mie && mie[11] && ext_pending;

	// --------------------
	// Trap request and target
	always_comb begin
		if (except_any || !mtvec_reg[0])
			vector_sel = '0;                      // Direct mode
		else if (std_active)
			vector_sel = {2'b00, std_num};
		else if (ext_active)
			vector_sel = {1'b0, ext_num} + 6'd16;
		else
			vector_sel = '0;
	end

	assign trap_addr = is_mret ? mepc :
		(mtvec_reg & ~32'h3) + XLEN'({vector_sel, 2'b00});
	assign trap_is_irq    = !except_any;
	assign trap_enter_vld = except_any || std_active || ext_active;

	assign view = '{
		mstatus_mie:  mstatus_mie,
		mstatus_mpie: mstatus_mpie,
		mtvec_reg:    mtvec_reg,
		mepc:         mepc,
		mcause_irq:   mcause_irq,
		mcause_code:  mcause_code,
		mie:          mie,
		mip:          mip,
		meie0:        meie0,
		meip0:        XLEN'(irq_r),
		mlei:         ext_num,
		mscratch:     mscratch
	};

	// Holds across both trap entry and software writes
	a_mepc_aligned: assert property (@(posedge clk) disable iff (!rst_n) !mepc[0]);

	// Interrupts are globally masked by mstatus.MIE
	a_no_irq_when_masked: assert property (@(posedge clk) disable iff (!rst_n)
		(except == EXCEPT_NONE && !mstatus_mie) |-> !trap_enter_vld);

endmodule

//--- hw/csr_counters.sv
/* mcycle/minstret with mcountinhibit. Only the low W_COUNTER bits count;
   the bits above hold, so keep W_COUNTER at 64 for a compliant core. */
`timescale 1ns/1ps

module csr_counters import csr_pkg::*; #(
	parameter int W_COUNTER = 64
) (
	input  logic      clk,
	input  logic      rst_n,
	input  csr_wreq_t wreq,
	input  logic      instr_ret,
	output ctr_view_t view
);

	localparam logic [2*XLEN-1:0] INC_MASK = ~({(2*XLEN){1'b1}} << W_COUNTER);

	logic [XLEN-1:0] mcycle, mcycleh, minstret, minstreth;
	logic inhibit_cy, inhibit_ir;
	logic [2*XLEN-1:0] cycle_inc, instret_inc;
	logic [XLEN-1:0] inhibit_wr;

	// Increment only the low bits, the rest is carried over untouched
	assign cycle_inc   = (({mcycleh, mcycle} + 1'b1) & INC_MASK) |
		({mcycleh, mcycle} & ~INC_MASK);
	assign instret_inc = (({minstreth, minstret} + 1'b1) & INC_MASK) |
		({minstreth, minstret} & ~INC_MASK);
	assign inhibit_wr  = csr_update({29'h0, inhibit_ir, 1'b0, inhibit_cy}, wreq, 32'h5);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mcycle     <= '0;
			mcycleh    <= '0;
			minstret   <= '0;
			minstreth  <= '0;
			inhibit_cy <= 1'b0;
			inhibit_ir <= 1'b0;
		end else begin
			if (!inhibit_cy)
				{mcycleh, mcycle} <= cycle_inc;
			if (!inhibit_ir && instr_ret)
				{minstreth, minstret} <= instret_inc;
			// Software write comes last so it overrides the increment
			if (wreq.wen) begin
				case (wreq.addr)
					CSR_MCYCLE:        mcycle    <= csr_update(mcycle, wreq, '1);
					CSR_MCYCLEH:       mcycleh   <= csr_update(mcycleh, wreq, '1);
					CSR_MINSTRET:      minstret  <= csr_update(minstret, wreq, '1);
					CSR_MINSTRETH:     minstreth <= csr_update(minstreth, wreq, '1);
					CSR_MCOUNTINHIBIT: {inhibit_ir, inhibit_cy} <= {inhibit_wr[2], inhibit_wr[0]};
					default: ;
				endcase
			end
		end
	end

	assign view = '{
		mcycle:     mcycle,
		mcycleh:    mcycleh,
		minstret:   minstret,
		minstreth:  minstreth,
		inhibit_cy: inhibit_cy,
		inhibit_ir: inhibit_ir
	};

	// Inhibit must freeze the whole 64-bit cycle count
	a_cycle_frozen: assert property (@(posedge clk) disable iff (!rst_n)
		(inhibit_cy && !(wreq.wen && (wreq.addr == CSR_MCYCLE || wreq.addr == CSR_MCYCLEH)))
		|=> $stable({mcycleh, mcycle}));

endmodule

//--- hw/csr_read_decode.sv
/* Combinational read port and access check. Writes to MIP, MISA and MTVAL
   are legal but ignored; a write to a read-only ID is illegal. */
`timescale 1ns/1ps

module csr_read_decode import csr_pkg::*; (
	input  csr_addr_t       addr,
	input  logic            ren,
	input  logic            wen,
	input  trap_view_t      trap_view,
	input  ctr_view_t       ctr_view,
	output logic [XLEN-1:0] rdata,
	output logic            illegal
);

	localparam logic [XLEN-1:0] MISA_VAL = 32'h4000_1104; // RV32 I, M, C

	logic decode_match; // Address is implemented
	logic read_only;    // Address rejects writes

	always_comb begin
		decode_match = 1'b1;
		read_only    = 1'b0;
		rdata        = '0;
		case (addr)
			// --------------------
			// Information
			CSR_MISA:      rdata = MISA_VAL;
			CSR_MVENDORID: begin rdata = VENDOR_ID; read_only = 1'b1; end
			CSR_MARCHID:   begin rdata = ARCH_ID;   read_only = 1'b1; end
			CSR_MIMPID:    begin rdata = IMP_ID;    read_only = 1'b1; end
			CSR_MHARTID:   begin rdata = HART_ID;   read_only = 1'b1; end

			// --------------------
			// Trap handling
			CSR_MSTATUS: rdata = {
				19'h0,
				2'b11,                  // MPP, always M-mode
				3'h0,
				trap_view.mstatus_mpie,
				3'h0,
				trap_view.mstatus_mie,
				3'h0
			};
			CSR_MTVEC:    rdata = {trap_view.mtvec_reg[XLEN-1:2], 1'b0, trap_view.mtvec_reg[0]};
			CSR_MSCRATCH: rdata = trap_view.mscratch;
			CSR_MEPC:     rdata = trap_view.mepc;
			CSR_MCAUSE:   rdata = {trap_view.mcause_irq, 26'h0, trap_view.mcause_code};
			CSR_MTVAL:    rdata = '0; // Hardwired
			CSR_MIE:      rdata = trap_view.mie;
			CSR_MIP:      rdata = trap_view.mip;

			// Custom external interrupt registers
			CSR_MEIE0: rdata = trap_view.meie0;
			CSR_MEIP0: begin rdata = trap_view.meip0; read_only = 1'b1; end
			CSR_MLEI:  begin rdata = XLEN'(trap_view.mlei); read_only = 1'b1; end

			// --------------------
			// Counters
			CSR_MCYCLE:    rdata = ctr_view.mcycle;
			CSR_MCYCLEH:   rdata = ctr_view.mcycleh;
			CSR_MINSTRET:  rdata = ctr_view.minstret;
			CSR_MINSTRETH: rdata = ctr_view.minstreth;
			CSR_MCOUNTINHIBIT: rdata = {29'h0, ctr_view.inhibit_ir, 1'b0, ctr_view.inhibit_cy};

			default: decode_match = 1'b0; // HPM and everything else
		endcase

		illegal = (ren && !decode_match) || (wen && (!decode_match || read_only));

		// Idle port never traps
		if (!(ren || wen))
			a_idle_legal: assert (!illegal);
	end

endmodule

//--- hw/csr_top.sv
/* M-mode CSR block: same-cycle reads, writes land at the next edge.
   NUM_IRQ is limited to 16 by the mcause code width. */
`timescale 1ns/1ps

module csr_top import csr_pkg::*; #(
	parameter int              NUM_IRQ    = 16,
	parameter int              W_COUNTER  = 64,
	parameter logic [XLEN-1:0] MTVEC_INIT = 32'h0000_0000
) (
	input  logic               clk,
	input  logic               rst_n,
	// Register port
	input  csr_addr_t          addr,
	input  logic [XLEN-1:0]    wdata,
	input  logic               wen,
	input  logic               ren,
	input  csr_wtype_t         wtype,
	output logic [XLEN-1:0]    rdata,
	output logic               illegal,
	// Trap entry handshake
	output logic [XLEN-1:0]    trap_addr,
	output logic               trap_is_irq,
	output logic               trap_enter_vld,
	input  logic               trap_enter_rdy,
	input  logic [XLEN-1:0]    mepc_in,
	input  except_t            except,
	// Level interrupts
	input  logic [NUM_IRQ-1:0] irq,
	input  logic               irq_software,
	input  logic               irq_timer,
	input  logic               instr_ret
);

	csr_wreq_t  wreq;
	trap_view_t trap_view;
	ctr_view_t  ctr_view;

	// One bundle feeds both writable parts
	assign wreq = '{addr: addr, wdata: wdata, wen: wen, wtype: wtype};

	csr_trap_unit #(
		.NUM_IRQ    (NUM_IRQ),
		.MTVEC_INIT (MTVEC_INIT)
	) u_trap (
		.clk            (clk),
		.rst_n          (rst_n),
		.wreq           (wreq),
		.except         (except),
		.irq            (irq),
		.irq_software   (irq_software),
		.irq_timer      (irq_timer),
		.mepc_in        (mepc_in),
		.trap_enter_rdy (trap_enter_rdy),
		.trap_addr      (trap_addr),
		.trap_is_irq    (trap_is_irq),
		.trap_enter_vld (trap_enter_vld),
		.view           (trap_view)
	);

	csr_counters #(.W_COUNTER(W_COUNTER)) u_counters (
		.clk       (clk),
		.rst_n     (rst_n),
		.wreq      (wreq),
		.instr_ret (instr_ret),
		.view      (ctr_view)
	);

	csr_read_decode u_read (
		.addr      (addr),
		.ren       (ren),
		.wen       (wen),
		.trap_view (trap_view),
		.ctr_view  (ctr_view),
		.rdata     (rdata),
		.illegal   (illegal)
	);

endmodule

//--- verification/csr_tb.sv
/* Command-driven testbench for csr_top, reads verification/csr_stim.txt.
   Must be started from the project root so the stimulus path resolves. */
`timescale 1ns/1ps

module csr_tb import csr_pkg::*; ();

	localparam int TIMEOUT = 20; // Cycles allowed for trap_enter_vld to settle

	logic               clk;
	logic               rst_n;
	csr_addr_t          addr;
	logic [XLEN-1:0]    wdata;
	logic               wen;
	logic               ren;
	csr_wtype_t         wtype;
	logic [XLEN-1:0]    rdata;
	logic               illegal;
	logic [XLEN-1:0]    trap_addr;
	logic               trap_is_irq;
	logic               trap_enter_vld;
	logic               trap_enter_rdy;
	logic [XLEN-1:0]    mepc_in;
	except_t            except;
	logic [15:0]        irq;
	logic               irq_software;
	logic               irq_timer;
	logic               instr_ret;

	string cur_test;                        // Name field of the line being run
	int    n_tests, n_checks, n_errors;     // Whole run
	int    t_checks, t_errors;              // Current test only
	bit    aborted;                         // Set on timeout or missing file

	csr_top #(
		.NUM_IRQ    (16),
		.W_COUNTER  (64),
		.MTVEC_INIT (32'h0000_0000)
	) u_csr_top (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 100 MHz
	end

	// --------------------
	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		n_checks++;
		t_checks++;
		if (act !== exp) begin
			n_errors++;
			t_errors++;
			$display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	// W: one write strobe, lands at the second edge
	task automatic write_reg(input logic [31:0] a, input logic [31:0] kind,
		input logic [31:0] d);
		@(posedge clk);
		#1;
		addr  = a[11:0];
		wdata = d;
		wtype = csr_wtype_t'(kind[1:0]);
		wen   = 1'b1;
		@(posedge clk); // Register updates here
		#1;
		wen = 1'b0;
	endtask

	// R: same-cycle read, sampled mid-cycle
	task automatic read_check(input logic [31:0] a, r, w, exp_data, exp_ill);
		@(posedge clk);
		#1;
		addr = a[11:0];
		ren  = r[0];
		wen  = w[0];   // Lets a line probe write legality
		@(negedge clk);
		check_value("rdata", exp_data, rdata);
		check_value("illegal", exp_ill, 32'(illegal));
		@(posedge clk);
		#1;
		ren = 1'b0;
		wen = 1'b0;
	endtask

	// X: exception or MRET, ready held low for hold cycles, then accepted
	task automatic trap_check(input logic [31:0] code, pc, exp_addr, exp_irq, hold);
		@(posedge clk);
		#1;
		except         = except_t'(code[3:0]);
		mepc_in        = pc;
		trap_enter_rdy = 1'b0;
		for (int i = 0; i <= int'(hold); i++) begin
			@(negedge clk); // Same-cycle request, must hold under back-pressure
			check_value("trap_enter_vld", 32'd1, 32'(trap_enter_vld));
			check_value("trap_addr", exp_addr, trap_addr);
			check_value("trap_is_irq", exp_irq, 32'(trap_is_irq));
		end
		@(posedge clk);
		#1;
		trap_enter_rdy = 1'b1;
		@(posedge clk); // Handshake completes here
		#1;
		trap_enter_rdy = 1'b0;
		except         = EXCEPT_NONE;
	endtask

	// Q: set interrupt levels and wait for the expected request level
	task automatic irq_wait(input logic [31:0] lines, sw, tmr, exp_vld, exp_addr);
		int waited;
		@(posedge clk);
		#1;
		irq          = lines[15:0];
		irq_software = sw[0];
		irq_timer    = tmr[0];
		waited       = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (trap_enter_vld !== exp_vld[0] && waited < TIMEOUT);
		if (trap_enter_vld !== exp_vld[0]) begin
			$display("Timeout in test %s: trap_enter_vld did not reach %0d within %0d cycles",
				cur_test, exp_vld[0], TIMEOUT);
			n_errors++;
			t_errors++;
			aborted = 1'b1;
		end else if (exp_vld[0]) begin
			check_value("trap_addr", exp_addr, trap_addr);
			check_value("trap_is_irq", 32'd1, 32'(trap_is_irq));
		end else begin
			for (int i = 0; i < 4; i++) begin
				@(negedge clk); // Must stay quiet
				check_value("trap_enter_vld", 32'd0, 32'(trap_enter_vld));
			end
		end
	endtask

	// N: one-cycle retire pulses
	task automatic retire_pulses(input logic [31:0] count);
		for (int i = 0; i < int'(count); i++) begin
			@(posedge clk);
			#1;
			instr_ret = 1'b1;
			@(posedge clk);
			#1;
			instr_ret = 1'b0;
		end
	endtask

	task automatic end_test();
		$display("test %s: %0d checks, %0d errors", cur_test, t_checks, t_errors);
		n_tests++;
		t_checks = 0;
		t_errors = 0;
	endtask

	// --------------------
	initial begin
		int          fd;
		int          nf;
		string       line;
		byte         cmd;
		logic [31:0] f0, f1, f2, f3, f4;

		rst_n          = 1'b0;
		addr           = '0;
		wdata          = '0;
		wen            = 1'b0;
		ren            = 1'b0;
		wtype          = WTYPE_W;
		trap_enter_rdy = 1'b0;
		mepc_in        = '0;
		except         = EXCEPT_NONE;
		irq            = '0;
		irq_software   = 1'b0;
		irq_timer      = 1'b0;
		instr_ret      = 1'b0;
		n_tests        = 0;
		n_checks       = 0;
		n_errors       = 0;
		t_checks       = 0;
		t_errors       = 0;
		aborted        = 1'b0;
		cur_test       = "";
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		fd = $fopen("verification/csr_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file verification/csr_stim.txt");
			n_errors++;
			aborted = 1'b1;
		end
		while (!aborted && !$feof(fd)) begin
			line = "";
			nf   = $fgets(line, fd);
			if (nf > 1 && line.getc(0) != "#") begin // Skip blanks and column notes
				cmd = line.getc(0);
				nf  = $sscanf(line.substr(2, line.len() - 1), "%s %h %h %h %h %h",
					cur_test, f0, f1, f2, f3, f4);
				case (cmd)
					"W": write_reg(f0, f1, f2);
					"R": read_check(f0, f1, f2, f3, f4);
					"X": trap_check(f0, f1, f2, f3, f4);
					"Q": irq_wait(f0, f1, f2, f3, f4);
					"N": retire_pulses(f0);
					"E": end_test();
					default: begin
						$display("Unknown command %c in the stimulus file", cmd);
						n_errors++;
					end
				endcase
			end
		end
		if (fd != 0)
			$fclose(fd);

		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- verilog.f
hw/csr_pkg.sv
hw/csr_priority_encode.sv
hw/csr_trap_unit.sv
hw/csr_counters.sv
hw/csr_read_decode.sv
hw/csr_top.sv
verification/csr_tb.sv

//--- Makefile
# Verilator flow for the CSR block, run everything from the project root
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module csr_tb -o csr_sim
	./obj_dir/csr_sim | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module csr_top

clean:
	rm -rf obj_dir $(LOG)

//--- verification/csr_stim.txt
# cmd test, then hex fields: W addr wtype wdata | R addr ren wen rdata illegal
# X except mepc_in trap_addr is_irq hold | Q irq sw timer vld trap_addr | N pulses | E
R rw 305 1 0 00000000 0
W rw 340 0 12345678
R rw 340 1 0 12345678 0
W rw 340 1 0000ff00
R rw 340 1 0 1234ff78 0
W rw 340 2 12340000
R rw 340 1 0 0000ff78 0
W rw 304 0 ffffffff
R rw 304 1 0 00000888 0
W rw 305 0 ffffffff
R rw 305 1 0 fffffffd 0
E rw
R legal 7c0 1 0 00000000 1
R legal b03 1 0 00000000 1
R legal f11 1 1 00000000 1
R legal f11 1 0 00000000 0
R legal f12 1 0 0000001b 0
R legal 301 1 0 40001104 0
E legal
W trap 305 0 00001000
W trap 300 1 00000008
R trap 300 1 0 00001808 0
X trap 2 00000123 00001000 0 2
R trap 341 1 0 00000122 0
R trap 342 1 0 00000002 0
R trap 300 1 0 00001880 0
X trap e 00000000 00000122 0 0
R trap 300 1 0 00001888 0
E trap
W irq 305 0 00002001
Q irq 0000 0 1 1 0000201c
Q irq 0000 0 0 0 0
W irq be0 0 00000020
Q irq 0020 0 0 1 00002054
R irq fe4 1 0 00000005 0
R irq 344 1 0 00000800 0
W irq be0 0 00000000
Q irq 0020 0 0 0 0
Q irq 0000 0 0 0 0
E irq
W ctr 320 0 00000001
W ctr b00 0 0000abcd
R ctr b00 1 0 0000abcd 0
W ctr b02 0 ffffffff
W ctr b82 0 00000000
N ctr 1
R ctr b02 1 0 00000000 0
R ctr b82 1 0 00000001 0
W ctr 320 0 00000005
N ctr 3
R ctr b02 1 0 00000000 0
R ctr 320 1 0 00000005 0
E ctr
